/* src/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// architectural register and pc width
`define RV_XLEN 32
// x0 included in the count
`define RV_NUM_REGS 32

`define RV_RESET_PC 32'h0000_0000
// byte distance between sequential instructions
`define RV_INSN_STEP 32'd4

`endif

/* src/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // funct3 values, ADD and ADDI share one
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [6:0] F7_BASE = 7'b0000000;

  typedef logic [4:0] reg_idx_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } insn_fields_t;

  // lui, addi and add to a nonzero rd are the only register writers
  function automatic logic writes_rd(input insn_fields_t f);
    logic alu_op;
    alu_op = (f.opcode == OPC_LUI)
          || (f.opcode == OPC_OP_IMM && f.funct3 == F3_ADD)
          || (f.opcode == OPC_OP && f.funct3 == F3_ADD && f.funct7 == F7_BASE);
    return alu_op && (f.rd != '0);
  endfunction

endpackage

`default_nettype wire

/* src/rv_pipe_pkg.sv */
`default_nettype none
`include "rv_defines.svh"

package rv_pipe_pkg;

  // what occupies a stage, carried down to writeback for the trace
  typedef enum logic [2:0] {
    CYCLE_INVALID      = 3'd0,
    CYCLE_RESET        = 3'd1,
    CYCLE_NO_STALL     = 3'd2,
    CYCLE_TAKEN_BRANCH = 3'd4
  } cycle_status_e;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [31:0]         insn;
    cycle_status_e       status;
  } decode_stage_t;

  // a and b are the register operands as read in decode
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [31:0]         insn;
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    cycle_status_e       status;
  } execute_stage_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [31:0]         insn;
    logic [`RV_XLEN-1:0] o;
    cycle_status_e       status;
  } memory_stage_t;

  // no loads, so writeback carries the same fields as memory
  typedef memory_stage_t writeback_stage_t;

  typedef struct packed {
    logic                we;
    rv_isa_pkg::reg_idx_t rd;
    logic [`RV_XLEN-1:0] value;
  } bypass_t;

  typedef struct packed {
    logic                taken;
    logic [`RV_XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0]  pc;
    logic [31:0]          insn;
    cycle_status_e        status;
    logic                 rd_we;
    rv_isa_pkg::reg_idx_t rd;
    logic [`RV_XLEN-1:0]  rd_data;
  } wb_trace_t;

endpackage

`default_nettype wire

/* src/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rd_we,
  input  rv_isa_pkg::reg_idx_t rd,
  input  logic [`RV_XLEN-1:0]  rd_data,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  output logic [`RV_XLEN-1:0]  rs1_data,
  output logic [`RV_XLEN-1:0]  rs2_data
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // reads see the old value during a write, decode covers that case
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* src/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_fetch (
  input  logic                       clk,
  input  logic                       rst,
  input  rv_pipe_pkg::redirect_t     redirect,
  input  logic [31:0]                insn_from_imem,
  output logic [`RV_XLEN-1:0]        pc_to_imem,
  output rv_pipe_pkg::decode_stage_t decode_q
);
  import rv_pipe_pkg::*;

  logic [`RV_XLEN-1:0] pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else if (redirect.taken) begin
      pc <= redirect.target;
    end else begin
      pc <= pc + `RV_INSN_STEP;
    end
  end

  assign pc_to_imem = pc;

  // the instruction fetched down the wrong path becomes a bubble
  always_ff @(posedge clk) begin
    if (rst) begin
      decode_q <= '{pc: '0, insn: '0, status: CYCLE_RESET};
    end else if (redirect.taken) begin
      decode_q <= '{pc: '0, insn: '0, status: CYCLE_TAKEN_BRANCH};
    end else begin
      decode_q <= '{pc: pc, insn: insn_from_imem, status: CYCLE_NO_STALL};
    end
  end

endmodule

`default_nettype wire

/* src/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_decode (
  input  logic                        clk,
  input  logic                        rst,
  input  rv_pipe_pkg::decode_stage_t  decode_q,
  input  rv_pipe_pkg::redirect_t      redirect,
  input  rv_pipe_pkg::bypass_t        wb_bypass,
  output rv_isa_pkg::reg_idx_t        rs1,
  output rv_isa_pkg::reg_idx_t        rs2,
  input  logic [`RV_XLEN-1:0]         rs1_data,
  input  logic [`RV_XLEN-1:0]         rs2_data,
  output rv_pipe_pkg::execute_stage_t execute_q
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  insn_fields_t        f;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;

  assign f   = insn_fields_t'(decode_q.insn);
  assign rs1 = f.rs1;
  assign rs2 = f.rs2;

  // the register file write of this cycle lands only at the edge,
  // so a writeback match takes the bypass value instead
  always_comb begin
    op_a = rs1_data;
    op_b = rs2_data;
    if (wb_bypass.we && wb_bypass.rd == f.rs1) begin
      op_a = wb_bypass.value;
    end
    if (wb_bypass.we && wb_bypass.rd == f.rs2) begin
      op_b = wb_bypass.value;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_q <= '{pc: '0, insn: '0, a: '0, b: '0, status: CYCLE_RESET};
    end else if (redirect.taken) begin
      execute_q <= '{pc: '0, insn: '0, a: '0, b: '0, status: CYCLE_TAKEN_BRANCH};
    end else begin
      execute_q <= '{
        pc:     decode_q.pc,
        insn:   decode_q.insn,
        a:      op_a,
        b:      op_b,
        status: decode_q.status
      };
    end
  end

endmodule

`default_nettype wire

/* src/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_execute (
  input  logic                        clk,
  input  logic                        rst,
  input  rv_pipe_pkg::execute_stage_t execute_q,
  input  rv_pipe_pkg::bypass_t        wb_bypass,
  output rv_pipe_pkg::redirect_t      redirect,
  output rv_pipe_pkg::memory_stage_t  memory_q
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  insn_fields_t        f;
  bypass_t             mem_bypass;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] sum;
  logic [`RV_XLEN-1:0] result;
  logic                ops_equal;
  logic                br_taken;

  // the younger result in the memory stage wins over writeback
  function automatic logic [`RV_XLEN-1:0] fwd(
    input reg_idx_t            src,
    input logic [`RV_XLEN-1:0] reg_val
  );
    logic [`RV_XLEN-1:0] v;
    v = reg_val;
    if (mem_bypass.we && mem_bypass.rd == src) begin
      v = mem_bypass.value;
    end else if (wb_bypass.we && wb_bypass.rd == src) begin
      v = wb_bypass.value;
    end
    return v;
  endfunction

  assign f = insn_fields_t'(execute_q.insn);

  // result sitting in the memory stage under the writeback write rule
  assign mem_bypass = '{
    we:    writes_rd(insn_fields_t'(memory_q.insn)),
    rd:    memory_q.insn[11:7],
    value: memory_q.o
  };

  always_comb begin
    op_a = fwd(f.rs1, execute_q.a);
    op_b = fwd(f.rs2, execute_q.b);
  end

  assign imm_i = {{20{execute_q.insn[31]}}, execute_q.insn[31:20]};
  assign imm_b = {{19{execute_q.insn[31]}}, execute_q.insn[31], execute_q.insn[7],
                  execute_q.insn[30:25], execute_q.insn[11:8], 1'b0};

  // one adder for addi and add
  assign sum    = op_a + ((f.opcode == OPC_OP) ? op_b : imm_i);
  assign result = (f.opcode == OPC_LUI) ? {execute_q.insn[31:12], 12'b0} : sum;

  assign ops_equal = (op_a == op_b);

  always_comb begin
    br_taken = 1'b0;
    if (f.opcode == OPC_BRANCH) begin
      if (f.funct3 == F3_BEQ) begin
        br_taken = ops_equal;
      end else if (f.funct3 == F3_BNE) begin
        br_taken = !ops_equal;
      end
    end
  end

  assign redirect = '{taken: br_taken, target: execute_q.pc + imm_b};

  always_ff @(posedge clk) begin
    if (rst) begin
      memory_q <= '{pc: '0, insn: '0, o: '0, status: CYCLE_RESET};
    end else begin
      memory_q <= '{
        pc:     execute_q.pc,
        insn:   execute_q.insn,
        o:      result,
        status: execute_q.status
      };
    end
  end

endmodule

`default_nettype wire

/* src/rv_writeback.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_writeback (
  input  logic                       clk,
  input  logic                       rst,
  input  rv_pipe_pkg::memory_stage_t memory_q,
  output logic                       rd_we,
  output rv_isa_pkg::reg_idx_t       rd,
  output logic [`RV_XLEN-1:0]        rd_data,
  output rv_pipe_pkg::bypass_t       wb_bypass,
  output rv_pipe_pkg::wb_trace_t     trace
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  writeback_stage_t wb_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_q <= '{pc: '0, insn: '0, o: '0, status: CYCLE_RESET};
    end else begin
      wb_q <= memory_q;
    end
  end

  // bubbles carry insn 0 and so never write
  assign rd_we   = writes_rd(insn_fields_t'(wb_q.insn));
  assign rd      = wb_q.insn[11:7];
  assign rd_data = wb_q.o;

  assign wb_bypass = '{we: rd_we, rd: rd, value: rd_data};

  assign trace = '{
    pc:      wb_q.pc,
    insn:    wb_q.insn,
    status:  wb_q.status,
    rd_we:   rd_we,
    rd:      rd,
    rd_data: rd_data
  };

endmodule

`default_nettype wire

/* src/rv_pipeline_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_pipeline_top (
  input  logic                   clk,
  input  logic                   rst,
  output logic [`RV_XLEN-1:0]    pc_to_imem,
  input  logic [31:0]            insn_from_imem,
  output rv_pipe_pkg::wb_trace_t trace
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  decode_stage_t       decode_q;
  execute_stage_t      execute_q;
  memory_stage_t       memory_q;
  redirect_t           redirect;
  bypass_t             wb_bypass;
  reg_idx_t            rs1;
  reg_idx_t            rs2;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic                rd_we;
  reg_idx_t            rd;
  logic [`RV_XLEN-1:0] rd_data;

  rv_fetch u_fetch (
    .clk            (clk),
    .rst            (rst),
    .redirect       (redirect),
    .insn_from_imem (insn_from_imem),
    .pc_to_imem     (pc_to_imem),
    .decode_q       (decode_q)
  );

  rv_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .decode_q  (decode_q),
    .redirect  (redirect),
    .wb_bypass (wb_bypass),
    .rs1       (rs1),
    .rs2       (rs2),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .execute_q (execute_q)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rd_we    (rd_we),
    .rd       (rd),
    .rd_data  (rd_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute u_execute (
    .clk       (clk),
    .rst       (rst),
    .execute_q (execute_q),
    .wb_bypass (wb_bypass),
    .redirect  (redirect),
    .memory_q  (memory_q)
  );

  rv_writeback u_writeback (
    .clk       (clk),
    .rst       (rst),
    .memory_q  (memory_q),
    .rd_we     (rd_we),
    .rd        (rd),
    .rd_data   (rd_data),
    .wb_bypass (wb_bypass),
    .trace     (trace)
  );

endmodule

`default_nettype wire

/* dv/rv_pipeline_assert.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_pipeline_assert (
  input logic                   clk,
  input logic                   rst,
  input logic [`RV_XLEN-1:0]    pc_to_imem,
  input rv_pipe_pkg::wb_trace_t trace
);
  import rv_pipe_pkg::*;

  int failures;

  initial begin
    failures = 0;
  end

  status_valid: assert property (@(posedge clk) disable iff (rst)
    trace.status != CYCLE_INVALID)
    else begin
      $error("trace status is invalid");
      failures++;
    end

  no_x0_write: assert property (@(posedge clk) disable iff (rst)
    trace.rd_we |-> trace.rd != 5'd0)
    else begin
      $error("register write to x0");
      failures++;
    end

  // bubbles and reset cycles never write
  bubble_quiet: assert property (@(posedge clk) disable iff (rst)
    trace.status != CYCLE_NO_STALL |-> !trace.rd_we)
    else begin
      $error("register write outside a retire cycle");
      failures++;
    end

  pc_aligned: assert property (@(posedge clk) disable iff (rst)
    pc_to_imem[1:0] == 2'b00)
    else begin
      $error("fetch pc not word aligned");
      failures++;
    end

endmodule

bind rv_pipeline_top rv_pipeline_assert u_assert (
  .clk        (clk),
  .rst        (rst),
  .pc_to_imem (pc_to_imem),
  .trace      (trace)
);

`default_nettype wire

/* dv/rv_pipeline_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_pipeline_checker (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_pipe_pkg::wb_trace_t trace,
  input  int                     prog_len,
  input  int                     test_id,
  output logic                   test_done,
  output int                     pass_count,
  output int                     fail_count,
  output int                     error_count
);
  import rv_pipe_pkg::*;

  typedef struct packed {
    logic [31:0] next_pc;
    logic        taken;
    logic        we;
    logic [4:0]  rd;
    logic [31:0] value;
  } ref_result_t;

  logic [31:0] ref_regs [0:31];
  logic [31:0] ref_pc;
  logic [31:0] exp_insn;
  ref_result_t r;
  int          test_errors;
  int          reset_cycles;
  int          bubbles_exp;
  int          bubbles_seen;
  logic        started;

  // next pc and register write of one instruction
  function automatic ref_result_t rv_ref_step(input logic [31:0] insn, input logic [31:0] pc,
                                              input logic [31:0] regs [0:31]);
    ref_result_t res;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    a = regs[insn[19:15]];
    b = regs[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    res = '{next_pc: pc + 32'd4, taken: 1'b0, we: 1'b0, rd: insn[11:7], value: '0};
    if (insn[6:0] == 7'b0110111) begin
      res.we = 1'b1;
      res.value = {insn[31:12], 12'h0};
    end else if (insn[6:0] == 7'b0010011 && insn[14:12] == 3'b000) begin
      res.we = 1'b1;
      res.value = a + imm_i;
    end else if (insn[6:0] == 7'b0110011 && insn[14:12] == 3'b000 && insn[31:25] == 7'h0) begin
      res.we = 1'b1;
      res.value = a + b;
    end else if (insn[6:0] == 7'b1100011) begin
      if ((insn[14:12] == 3'b000 && a == b) || (insn[14:12] == 3'b001 && a != b)) begin
        res.taken = 1'b1;
        res.next_pc = pc + imm_b;
      end
    end
    if (res.rd == 5'd0) begin
      res.we = 1'b0;
    end
    return res;
  endfunction

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("MISMATCH %s expected %h got %h", name, exp, got);
    test_errors++;
  endtask

  task automatic failure(input string what);
    $display("test %0d: %s", test_id, what);
    test_errors++;
  endtask

  initial begin
    pass_count = 0;
    fail_count = 0;
    error_count = 0;
    test_done = 1'b0;
  end

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        ref_regs[i] = '0;
      end
      ref_pc = `RV_RESET_PC;
      test_errors = 0;
      reset_cycles = 0;
      bubbles_exp = 0;
      bubbles_seen = 0;
      started = 1'b0;
      test_done = 1'b0;
    end else if (!test_done) begin
      case (trace.status)
        CYCLE_RESET: begin
          if (started) begin
            failure("reset status seen after the first retire");
          end
          reset_cycles++;
          if (trace.pc != 0) mismatch("trace.pc", 32'h0, trace.pc);
          if (trace.rd_we) failure("register write during reset");
        end
        CYCLE_TAKEN_BRANCH: begin
          bubbles_seen++;
          if (bubbles_seen > bubbles_exp) failure("unexpected branch bubble");
          if (trace.rd_we) failure("register write from a branch bubble");
        end
        CYCLE_NO_STALL: begin
          if (!started && reset_cycles != 4) begin
            failure($sformatf("first retire after %0d reset cycles, not 4", reset_cycles));
          end
          started = 1'b1;
          if (bubbles_seen != bubbles_exp) begin
            failure($sformatf("%0d bubbles seen, %0d expected", bubbles_seen, bubbles_exp));
          end
          exp_insn = ((ref_pc >> 2) < prog_len) ? rv_pipeline_tb.prog[ref_pc >> 2]
                                                : 32'h0000_0013;
          r = rv_ref_step(exp_insn, ref_pc, ref_regs);
          if (trace.pc != ref_pc) mismatch("trace.pc", ref_pc, trace.pc);
          if (trace.insn != exp_insn) mismatch("trace.insn", exp_insn, trace.insn);
          if (trace.rd_we != r.we) mismatch("trace.rd_we", 32'(r.we), 32'(trace.rd_we));
          if (trace.rd != r.rd) mismatch("trace.rd", 32'(r.rd), 32'(trace.rd));
          if (r.we && trace.rd_data != r.value) mismatch("trace.rd_data", r.value, trace.rd_data);
          if (r.we) ref_regs[r.rd] = r.value;
          bubbles_exp = r.taken ? 2 : 0;
          bubbles_seen = 0;
          ref_pc = r.next_pc;
          if ((ref_pc >> 2) >= prog_len) begin
            $display("test %0d finished with %0d errors", test_id, test_errors);
            if (test_errors == 0) pass_count++;
            else fail_count++;
            error_count += test_errors;
            test_done = 1'b1;
          end
        end
        default: failure($sformatf("invalid cycle status %0h", trace.status));
      endcase
    end
  end

endmodule

`default_nettype wire

/* dv/rv_pipeline_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_pipeline_tb;
  import rv_pipe_pkg::*;

  localparam int NUM_TESTS = 5;
  localparam int MEM_WORDS = 256;
  localparam logic [31:0] NOP = 32'h0000_0013;

  logic                clk;
  logic                rst;
  logic [`RV_XLEN-1:0] pc_to_imem;
  logic [31:0]         insn_from_imem;
  wb_trace_t           trace;

  logic [31:0] prog [0:MEM_WORDS-1];
  int          prog_len;
  int          branch_count;
  int          test_id;
  logic [31:0] lcg_state;
  logic        test_done;
  int          pass_count;
  int          fail_count;
  int          error_count;
  longint      budget_ns;

  always #4 clk = ~clk;

  rv_pipeline_top dut_i (
    .clk            (clk),
    .rst            (rst),
    .pc_to_imem     (pc_to_imem),
    .insn_from_imem (insn_from_imem),
    .trace          (trace)
  );

  rv_pipeline_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .trace       (trace),
    .prog_len    (prog_len),
    .test_id     (test_id),
    .test_done   (test_done),
    .pass_count  (pass_count),
    .fail_count  (fail_count),
    .error_count (error_count)
  );

  // outside the program the memory returns addi x0, x0, 0
  always @(negedge clk) begin
    if ((pc_to_imem >> 2) < prog_len) begin
      insn_from_imem = prog[pc_to_imem >> 2];
    end else begin
      insn_from_imem = NOP;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'h0, lcg_state[30:15]};
  endfunction

  function automatic logic [31:0] enc_lui(input int rd, input logic [19:0] imm);
    return {imm, rd[4:0], 7'b0110111};
  endfunction

  function automatic logic [31:0] enc_addi(input int rd, input int rs1, input logic [11:0] imm);
    return {imm, rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_add(input int rd, input int rs1, input int rs2);
    return {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
  endfunction

  // bne when ne is set and beq when it is clear
  function automatic logic [31:0] enc_branch(input logic ne, input int rs1, input int rs2,
                                             input logic [12:0] off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], 2'b00, ne,
            off[4:1], off[11], 7'b1100011};
  endfunction

  task automatic emit(input logic [31:0] word);
    prog[prog_len] = word;
    if (word[6:0] == 7'b1100011) begin
      branch_count++;
    end
    prog_len++;
  endtask

  task automatic build_program(input int t);
    int kind;
    prog_len = 0;
    branch_count = 0;
    lcg_state = 32'd97911;
    case (t)
      0: begin
        emit(enc_addi(1, 0, 12'd5));
        emit(enc_addi(2, 0, 12'd7));
      end
      1: begin
        // distances 1 and 2 through memory and writeback forwarding
        emit(enc_lui(1, 20'h12345));
        emit(enc_addi(1, 1, 12'h678));
        emit(enc_addi(2, 1, 12'hfff));
        emit(enc_add(3, 2, 1));
        emit(enc_addi(4, 0, 12'd3));
        emit(enc_add(5, 3, 1));
        // distance 3 goes through decode forwarding
        emit(enc_addi(1, 0, 12'd9));
        emit(enc_addi(6, 0, 12'd1));
        emit(enc_addi(7, 0, 12'd2));
        emit(enc_add(2, 1, 0));
        emit(enc_add(7, 4, 5));
      end
      2: begin
        emit(enc_addi(1, 0, 12'd3));
        emit(enc_addi(2, 0, 12'd3));
        emit(enc_branch(1'b0, 1, 2, 13'd12));
        emit(enc_addi(3, 0, 12'd1));
        emit(enc_addi(3, 0, 12'd2));
        emit(enc_addi(4, 0, 12'd4));
        emit(enc_branch(1'b1, 1, 4, 13'd8));
        emit(enc_addi(5, 0, 12'd1));
        emit(enc_addi(6, 0, 12'd6));
        emit(enc_branch(1'b0, 1, 4, 13'd8));
        emit(enc_branch(1'b1, 1, 2, 13'd8));
        emit(enc_addi(7, 0, 12'd7));
      end
      3: begin
        emit(enc_addi(0, 0, 12'd55));
        emit(enc_lui(0, 20'hfffff));
        emit(enc_addi(1, 0, 12'd0));
        emit(enc_add(2, 0, 0));
        emit(enc_branch(1'b0, 0, 1, 13'd8));
        emit(enc_addi(3, 0, 12'd1));
        emit(enc_addi(4, 0, 12'd2));
      end
      default: begin
        for (int i = 0; i < 200; i++) begin
          kind = lcg_next() % 5;
          case (kind)
            0: emit(enc_lui(1 + lcg_next() % 7, lcg_next()));
            1: emit(enc_addi(1 + lcg_next() % 7, lcg_next() % 8, lcg_next()));
            2: emit(enc_add(1 + lcg_next() % 7, lcg_next() % 8, lcg_next() % 8));
            default: emit(enc_branch(kind[0], lcg_next() % 8, lcg_next() % 8,
                                     13'(4 * (1 + lcg_next() % 4))));
          endcase
        end
      end
    endcase
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    insn_from_imem = NOP;
    prog_len = 0;
    branch_count = 0;
    test_id = 0;
    lcg_state = 32'd97911;
    budget_ns = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      build_program(t);
      budget_ns += (prog_len + 2 * branch_count + 10) * 8;
    end
    budget_ns = budget_ns * 2;

    fork
      begin
        #(budget_ns * 1ns);
        $display("timeout: test %0d did not finish within %0d ns", test_id, budget_ns);
        $display("TEST FAIL");
        $finish;
      end
    join_none

    for (int t = 0; t < NUM_TESTS; t++) begin
      @(negedge clk);
      rst = 1'b1;
      test_id = t;
      build_program(t);
      repeat (10) @(negedge clk);
      rst = 1'b0;
      wait (test_done);
      @(negedge clk);
    end

    $display("tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
             pass_count, fail_count, error_count, dut_i.u_assert.failures);
    if (fail_count == 0 && error_count == 0 && dut_i.u_assert.failures == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_regfile.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_writeback.sv
src/rv_pipeline_top.sv
dv/rv_pipeline_assert.sv
dv/rv_pipeline_checker.sv
dv/rv_pipeline_tb.sv
